/* hw/byte_ram.sv */
`timescale 1ns/1ps
`include "mem_subsys_cfg.svh"

module byte_ram (
    input  logic                   CLK,
    input  mem_subsys_pkg::addr_t  addr,
    input  logic                   we,
    input  mem_subsys_pkg::byte_t  wdata,
    output mem_subsys_pkg::byte_t  rdata
);

    import mem_subsys_pkg::*;

    byte_t mem [`MEM_BYTES];   // contents are undefined until written
    addr_t index;              // address folded into the array

    // accesses past the end wrap back to the start of the array
    assign index = addr_t'(addr % `MEM_BYTES);

    assign rdata = mem[index];  // read is combinational so a load byte lands in the same cycle

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

endmodule

/* hw/lane_sequencer.sv */
`timescale 1ns/1ps

module lane_sequencer (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  logic                        grant_valid,
    input  mem_subsys_pkg::mem_req_t    grant_req,
    input  mem_subsys_pkg::client_id_t  grant_id,
    output logic                        seq_ready,
    output mem_subsys_pkg::addr_t       ram_addr,
    output logic                        ram_we,
    output mem_subsys_pkg::byte_t       ram_wdata,
    input  mem_subsys_pkg::byte_t       ram_rdata,
    output logic [1:0]                  rsp_valid,
    output mem_subsys_pkg::mem_rsp_t    rsp
);

    import mem_subsys_pkg::*;

    seq_state_e state;
    mem_req_t   req_q;         // request being served
    client_id_t id_q;          // owner of that request
    lane_mask_t lanes_left;    // lanes not yet accessed
    lane_mask_t lanes_rest;    // lanes left after the current one
    word_t      rdata_q;       // response word being assembled
    logic       err_q;
    logic [1:0] lane;          // highest pending lane, the one accessed this cycle
    logic       mask_legal;

    // only byte, aligned half-word and full word frames are supported
    always_comb begin
        case (grant_req.mask)
            4'b0001, 4'b0010, 4'b0100, 4'b1000,
            4'b0011, 4'b1100, 4'b1111: mask_legal = 1'b1;
            default:                   mask_legal = 1'b0;
        endcase
    end

    // later hits overwrite earlier ones, so lane 3 has the highest priority
    always_comb begin
        lane = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (lanes_left[i]) begin
                lane = 2'(i);
            end
        end
    end

    assign lanes_rest = lanes_left & ~(lane_mask_t'(1) << lane);

    // big endian, lane 3 sits at the base address and lane 0 at base + 3
    assign ram_addr  = req_q.addr + addr_t'(2'd3 - lane);
    assign ram_we    = (state == ACCESS) && req_q.write;
    assign ram_wdata = req_q.wdata[{lane, 3'b000} +: 8];

    assign seq_ready = (state == IDLE);
    assign rsp_valid = (state == RESPOND) ? (2'b01 << id_q) : 2'b00;
    assign rsp.rdata = rdata_q;
    assign rsp.err   = err_q;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            lanes_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (grant_valid) begin
                        // an illegal frame skips the ram and answers right away
                        state      <= mask_legal ? ACCESS : RESPOND;
                        lanes_left <= mask_legal ? grant_req.mask : '0;
                    end
                end
                ACCESS: begin
                    lanes_left <= lanes_rest;
                    if (lanes_rest == '0) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if ((state == IDLE) && grant_valid) begin
            req_q   <= grant_req;
            id_q    <= grant_id;
            err_q   <= !mask_legal;
            rdata_q <= '0;                                 // unselected lanes stay zero
        end else if ((state == ACCESS) && !req_q.write) begin
            rdata_q[{lane, 3'b000} +: 8] <= ram_rdata;     // merge the byte into its lane
        end
    end

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                        CLK,
    input  logic                        arst_n,
    input  logic [1:0]                  head_valid,
    input  mem_subsys_pkg::mem_req_t    head_req0,
    input  mem_subsys_pkg::mem_req_t    head_req1,
    input  logic                        seq_ready,
    output logic [1:0]                  pop,
    output logic                        grant_valid,
    output mem_subsys_pkg::mem_req_t    grant_req,
    output mem_subsys_pkg::client_id_t  grant_id
);

    import mem_subsys_pkg::*;

    client_id_t last_winner;   // client granted most recently
    client_id_t pick;          // client that would win this cycle

    // round robin, the loser of the last contest goes first
    always_comb begin
        if (head_valid[0] && head_valid[1]) begin
            pick = ~last_winner;
        end else if (head_valid[1]) begin
            pick = 1'b1;
        end else begin
            pick = 1'b0;
        end
    end

    // nothing leaves a queue unless the sequencer can take it in the same cycle
    assign grant_valid = seq_ready && (|head_valid);
    assign pop         = grant_valid ? (2'b01 << pick) : 2'b00;
    assign grant_req   = pick ? head_req1 : head_req0;
    assign grant_id    = pick;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            last_winner <= 1'b1;        // fetch port wins the first contest
        end else if (grant_valid) begin
            last_winner <= pick;
        end
    end

endmodule

/* hw/mem_req_queue.sv */
`timescale 1ns/1ps
`include "mem_subsys_cfg.svh"

module mem_req_queue (
    input  logic                      CLK,
    input  logic                      arst_n,
    input  logic                      push,
    input  mem_subsys_pkg::mem_req_t  push_req,
    input  logic                      pop,
    output logic                      head_valid,
    output mem_subsys_pkg::mem_req_t  head_req,
    output logic                      credit
);

    import mem_subsys_pkg::*;

    localparam int PTR_W = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    mem_req_t         entries [`QUEUE_DEPTH];  // circular buffer storage
    logic [PTR_W-1:0] wr_ptr;                  // next slot to fill
    logic [PTR_W-1:0] rd_ptr;                  // current head slot
    logic [CNT_W-1:0] count;                   // occupied entries

    // step a pointer around the ring, also correct for a depth that is not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_req   = entries[rd_ptr];      // only meaningful while head_valid is high

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither leaves the level unchanged
            endcase
            credit <= pop;                    // one credit back for each entry that left
        end
    end

    // the entry is visible at the head one cycle after the push
    always_ff @(posedge CLK) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

endmodule

/* hw/mem_subsys_pkg.sv */
`include "mem_subsys_cfg.svh"

package mem_subsys_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;                    // byte address into the ram
    typedef logic [31:0]        word_t;                    // data word as seen by a client
    typedef logic [3:0]         lane_mask_t;               // frame mask, bit 3 is the lowest address
    typedef logic [7:0]         byte_t;                    // one ram location
    typedef logic [$clog2(`NUM_CLIENTS)-1:0] client_id_t;  // 0 is fetch, 1 is load/store

    // one client request as it sits in a queue
    typedef struct packed {
        logic       write;   // high for a store, low for a load
        addr_t      addr;    // byte address of lane 3
        lane_mask_t mask;    // lanes to touch
        word_t      wdata;   // store data, only the masked lanes are used
    } mem_req_t;

    // response handed back to the issuing client
    typedef struct packed {
        word_t rdata;        // load data, unselected lanes read as zero
        logic  err;          // set when the mask was not one of the legal patterns
    } mem_rsp_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,                // waiting for a grant
        ACCESS,              // one byte per cycle
        RESPOND              // response valid for one cycle
    } seq_state_e;

endpackage

/* hw/mem_subsys_top.sv */
`timescale 1ns/1ps
`include "mem_subsys_cfg.svh"

module mem_subsys_top (
    input  logic                             CLK,
    input  logic                             arst_n,
    input  logic [`NUM_CLIENTS-1:0]          req_valid,
    input  mem_subsys_pkg::mem_req_t         req0,
    input  mem_subsys_pkg::mem_req_t         req1,
    output logic [`NUM_CLIENTS-1:0]          credit,
    output logic [`NUM_CLIENTS-1:0]          rsp_valid,
    output mem_subsys_pkg::mem_rsp_t         rsp0,
    output mem_subsys_pkg::mem_rsp_t         rsp1
);

    import mem_subsys_pkg::*;

    logic [`NUM_CLIENTS-1:0] head_valid;
    logic [`NUM_CLIENTS-1:0] pop;
    mem_req_t                head_req0;
    mem_req_t                head_req1;
    logic                    grant_valid;
    mem_req_t                grant_req;
    client_id_t              grant_id;
    logic                    seq_ready;
    addr_t                   ram_addr;
    logic                    ram_we;
    byte_t                   ram_wdata;
    byte_t                   ram_rdata;
    mem_rsp_t                rsp;

    mem_req_queue fetch_queue_inst (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .push       (req_valid[0]),
        .push_req   (req0),
        .pop        (pop[0]),
        .head_valid (head_valid[0]),
        .head_req   (head_req0),
        .credit     (credit[0])
    );

    mem_req_queue lsu_queue_inst (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .push       (req_valid[1]),
        .push_req   (req1),
        .pop        (pop[1]),
        .head_valid (head_valid[1]),
        .head_req   (head_req1),
        .credit     (credit[1])
    );

    mem_arbiter mem_arbiter_inst (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .head_valid  (head_valid),
        .head_req0   (head_req0),
        .head_req1   (head_req1),
        .seq_ready   (seq_ready),
        .pop         (pop),
        .grant_valid (grant_valid),
        .grant_req   (grant_req),
        .grant_id    (grant_id)
    );

    lane_sequencer lane_sequencer_inst (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .grant_valid (grant_valid),
        .grant_req   (grant_req),
        .grant_id    (grant_id),
        .seq_ready   (seq_ready),
        .ram_addr    (ram_addr),
        .ram_we      (ram_we),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    byte_ram byte_ram_inst (
        .CLK   (CLK),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // both clients see the same payload, rsp_valid tells which one owns it
    assign rsp0 = rsp;
    assign rsp1 = rsp;

endmodule

/* include/mem_subsys_cfg.svh */
`ifndef MEM_SUBSYS_CFG_SVH
`define MEM_SUBSYS_CFG_SVH

// size of the byte array behind the sequencer
`define MEM_BYTES 1024

// byte address width, enough to cover MEM_BYTES
`define ADDR_W 10

// entries in each client queue
// each client also starts with this many credits after reset
`define QUEUE_DEPTH 4

// fetch port and load/store port, the arbiter is built for exactly two
`define NUM_CLIENTS 2

`endif

/* mem_subsys.f */
+incdir+include
hw/mem_subsys_pkg.sv
hw/mem_req_queue.sv
hw/mem_arbiter.sv
hw/lane_sequencer.sv
hw/byte_ram.sv
hw/mem_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/mem_subsys_checker.sv
testbench/tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build and run the mem_subsys testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mem_subsys -f mem_subsys.f -o sim_mem_subsys
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_subsys)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* testbench/mem_subsys_checker.sv */
`timescale 1ns/1ps
`include "mem_subsys_cfg.svh"

module mem_subsys_checker (
    input logic       CLK,
    input logic       arst_n,
    input logic [1:0] req_valid,
    input logic [1:0] pop,
    input logic [1:0] credit,
    input logic [1:0] rsp_valid
);

    int occ [2];    // queue levels rebuilt from pushes and pops
    int owed [2];   // requests pushed that have not been answered yet

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            occ[0]  <= 0;
            occ[1]  <= 0;
            owed[0] <= 0;
            owed[1] <= 0;
        end else begin
            occ[0]  <= occ[0] + int'(req_valid[0]) - int'(pop[0]);
            occ[1]  <= occ[1] + int'(req_valid[1]) - int'(pop[1]);
            owed[0] <= owed[0] + int'(req_valid[0]) - int'(rsp_valid[0]);
            owed[1] <= owed[1] + int'(req_valid[1]) - int'(rsp_valid[1]);
        end
    end

    push_room_0: assert property (@(posedge CLK) disable iff (!arst_n)
        req_valid[0] |-> occ[0] < `QUEUE_DEPTH) else $error("fetch queue pushed while full");
    push_room_1: assert property (@(posedge CLK) disable iff (!arst_n)
        req_valid[1] |-> occ[1] < `QUEUE_DEPTH) else $error("lsu queue pushed while full");
    single_pop: assert property (@(posedge CLK) disable iff (!arst_n)
        $onehot0(pop) && !(pop[0] && occ[0] == 0) && !(pop[1] && occ[1] == 0))
        else $error("pop from an empty queue or from both queues in one cycle");
    single_rsp: assert property (@(posedge CLK) disable iff (!arst_n)
        $onehot0(rsp_valid) && !(rsp_valid[0] && owed[0] == 0)
        && !(rsp_valid[1] && owed[1] == 0))
        else $error("response sent to both clients or to a client with nothing pending");
    credit_0: assert property (@(posedge CLK) disable iff (!arst_n)
        credit[0] |-> $past(pop[0]) && owed[0] > 0) else $error("fetch credit without a pop");
    credit_1: assert property (@(posedge CLK) disable iff (!arst_n)
        credit[1] |-> $past(pop[1]) && owed[1] > 0) else $error("lsu credit without a pop");

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic CLK,
    output logic arst_n
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;           // 4 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge CLK);
        arst_n <= 1'b1;                  // release on a rising edge after 10 cycles
    end

endmodule

/* testbench/tb_mem_subsys.sv */
`timescale 1ns/1ps
`include "mem_subsys_cfg.svh"

module tb_mem_subsys;

    import mem_subsys_pkg::*;

    localparam int WAIT_LIMIT = 200;  // cycles any single wait may take

    logic        CLK;
    logic        arst_n;
    logic [1:0]  req_valid;
    mem_req_t    req0;
    mem_req_t    req1;
    logic [1:0]  credit;
    logic [1:0]  rsp_valid;
    mem_rsp_t    rsp0;
    mem_rsp_t    rsp1;
    byte_t       model [`MEM_BYTES];  // reference copy of the ram
    mem_rsp_t    exp_q [2][$];        // responses each client should get, in order
    mem_rsp_t    got_q [2][$];        // responses seen on each client port
    int          issued [2];
    int          returned [2];        // credit pulses seen per client
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;
    logic [31:0] lfsr;

    tb_clock_gen tb_clock_gen_inst (.CLK(CLK), .arst_n(arst_n));

    mem_subsys_top mem_subsys_top_inst (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req0      (req0),
        .req1      (req1),
        .credit    (credit),
        .rsp_valid (rsp_valid),
        .rsp0      (rsp0),
        .rsp1      (rsp1)
    );

    bind mem_subsys_top mem_subsys_checker mem_subsys_checker_inst (
        .CLK(CLK), .arst_n(arst_n), .req_valid(req_valid),
        .pop(pop), .credit(credit), .rsp_valid(rsp_valid)
    );

    // outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge CLK) begin
        for (int c = 0; c < 2; c++) begin
            if (credit[c]) begin
                returned[c]++;
            end
            if (returned[c] > issued[c]) begin
                $display("client %0d holds more credits than requests it issued", c);
                errors++;
            end
        end
        if (rsp_valid[0]) begin
            got_q[0].push_back(rsp0);
        end
        if (rsp_valid[1]) begin
            got_q[1].push_back(rsp1);
        end
    end

    function automatic int avail(input int c);
        return `QUEUE_DEPTH + returned[c] - issued[c];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // lanes are big endian, mask bit 3 is the base address and data bits 31:24
    function automatic mem_rsp_t model_access(input mem_req_t r);
        mem_rsp_t e;
        addr_t    a;
        e = '0;
        e.err = !(r.mask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111});
        for (int k = 0; k < 4; k++) begin
            a = r.addr + addr_t'(k);              // wraps inside the memory
            if (r.mask[3 - k] && !e.err && r.write) begin
                model[a] = r.wdata[8 * (3 - k) +: 8];
            end else if (r.mask[3 - k] && !e.err) begin
                e.rdata[8 * (3 - k) +: 8] = model[a];
            end
        end
        return e;
    endfunction

    // each client keeps to its own half so the two can run in any order
    function automatic mem_req_t rand_req(input logic c);
        lane_mask_t legal [7];
        mem_req_t   r;
        legal = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
        r.write = 1'(rand_bits(1));
        r.addr  = {c, 1'b0, 8'(rand_bits(8))};
        r.mask  = legal[3'(rand_bits(3) % 7)];
        r.wdata = rand_bits(32);
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_at_start);
        end
    endtask

    // waits for a credit on every selected client, then pushes for one cycle
    task automatic send(input logic [1:0] which, input mem_req_t r0, input mem_req_t r1);
        int waited;
        waited = 0;
        @(posedge CLK);
        while (((which[0] && avail(0) < 1) || (which[1] && avail(1) < 1)) && !timed_out) begin
            @(posedge CLK);
            waited++;
            if (waited > WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout, no credit came back within %0d cycles", WAIT_LIMIT);
            end
        end
        if (!timed_out) begin
            if (which[0]) begin
                exp_q[0].push_back(model_access(r0));
                issued[0]++;
            end
            if (which[1]) begin
                exp_q[1].push_back(model_access(r1));
                issued[1]++;
            end
            req0      <= r0;
            req1      <= r1;
            req_valid <= which;
            @(posedge CLK);
            req_valid <= 2'b00;
        end
    endtask

    task automatic drain(input string name);
        int waited;
        waited = 0;
        while ((got_q[0].size() < exp_q[0].size() || got_q[1].size() < exp_q[1].size())
               && !timed_out) begin
            @(posedge CLK);
            waited++;
            if (waited > WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("timeout in %s, responses still missing", name);
            end
        end
        for (int c = 0; c < 2; c++) begin
            while (exp_q[c].size() > 0 && got_q[c].size() > 0) begin
                check(name, 64'(exp_q[c].pop_front()), 64'(got_q[c].pop_front()));
            end
            check(name, 64'(exp_q[c].size()), 64'(got_q[c].size()));  // leftovers on either side
            exp_q[c].delete();
            got_q[c].delete();
        end
    endtask

    // every byte gets a value built from all ten address bits
    task automatic fill_memory();
        mem_req_t r;
        addr_t    a;
        errors_at_start = errors;
        for (int w = 0; w < `MEM_BYTES / 4; w++) begin
            r.write = 1'b1;
            r.addr  = addr_t'(4 * w);
            r.mask  = 4'b1111;
            for (int k = 0; k < 4; k++) begin
                a = r.addr + addr_t'(k);
                r.wdata[8 * (3 - k) +: 8] = a[7:0] ^ {4{a[9:8]}};
            end
            send(2'b01, r, r);
        end
        drain("fill");
        end_test("fill");
    endtask

    task automatic test_word_rw();
        addr_t    addrs [4];
        mem_req_t r;
        addrs = '{10'h000, 10'h104, 10'h2a8, 10'h3fe};  // the last word wraps past the top
        errors_at_start = errors;
        foreach (addrs[i]) begin
            r = '{write: 1'b1, addr: addrs[i], mask: 4'b1111, wdata: rand_bits(32)};
            send(2'b10, r, r);
            r.write = 1'b0;
            send(2'b10, r, r);
        end
        drain("word_rw");
        end_test("word_rw");
    endtask

    task automatic test_masks();
        lane_mask_t masks [6];
        mem_req_t   w;
        mem_req_t   rd;
        masks = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100};
        errors_at_start = errors;
        foreach (masks[i]) begin
            w = '{write: 1'b1, addr: addr_t'(10'h040 + 4 * i), mask: masks[i],
                  wdata: rand_bits(32)};
            rd = w;
            rd.write = 1'b0;
            rd.mask  = 4'b1111;
            send(2'b10, w, w);
            send(2'b10, rd, rd);   // untouched lanes still hold the fill pattern
            rd.mask = masks[i];
            send(2'b10, rd, rd);   // unselected lanes come back zero
        end
        drain("masks");
        end_test("masks");
    endtask

    task automatic test_illegal();
        mem_req_t r;
        errors_at_start = errors;
        r = '{write: 1'b1, addr: 10'h080, mask: 4'b0000, wdata: rand_bits(32)};
        send(2'b01, r, r);
        r.mask = 4'b0101;
        send(2'b01, r, r);
        r.write = 1'b0;
        r.mask  = 4'b1111;
        send(2'b01, r, r);
        drain("illegal");
        end_test("illegal");
    endtask

    task automatic test_burst();
        mem_req_t r0;
        mem_req_t r1;
        errors_at_start = errors;
        repeat (`QUEUE_DEPTH) begin
            r0 = rand_req(1'b0);
            r1 = rand_req(1'b1);
            send(2'b11, r0, r1);
        end
        drain("burst");
        end_test("burst");
    endtask

    task automatic test_credits();
        mem_req_t r;
        logic     ran_dry;
        errors_at_start = errors;
        ran_dry = 1'b0;
        for (int i = 0; i < 3 * `QUEUE_DEPTH; i++) begin
            r = rand_req(1'b1);
            r.mask = 4'b1111;      // word accesses drain slower than they are issued
            send(2'b10, r, r);
            if (avail(1) == 0) begin
                ran_dry = 1'b1;
            end
        end
        drain("credits");
        check("credits", 64'(1), 64'(ran_dry));
        check("credits", 64'(issued[1]), 64'(returned[1]));
        check("credits", 64'(`QUEUE_DEPTH), 64'(avail(1)));
        end_test("credits");
    endtask

    initial begin
        int waited;
        req_valid = 2'b00;
        req0      = '0;
        req1      = '0;
        lfsr      = 32'hcdb7_b095;
        timed_out = 1'b0;
        waited    = 0;
        while (arst_n !== 1'b1 && !timed_out) begin
            @(posedge CLK);
            waited++;
            if (waited > 50) begin
                timed_out = 1'b1;
                $display("timeout, reset was never released");
            end
        end
        fill_memory();
        test_word_rw();
        test_masks();
        test_illegal();
        test_burst();
        test_credits();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
